/* Makefile */
# Verilator build and run for the peripheral bus wrapper testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_periph_top
FILELIST = periph_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* periph_top.f */
rtl/periph_pkg.sv
rtl/periph_decode.sv
rtl/read_return.sv
rtl/gpio_regs.sv
rtl/pin_mux.sv
rtl/scratch_regs.sv
rtl/edge_counter.sv
rtl/periph_top.sv
sim/periph_top_assert.sv
sim/tb_periph_top.sv

/* rtl/edge_counter.sv */
// Rising edge counter
// Byte peripheral counting 0-to-1 transitions on one selectable input pin
`timescale 1ns/1ps

module edge_counter
    import periph_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_wr,
    input  logic [SIMPLE_OFS_W-1:0] i_offset,
    input  logic [BYTE_W-1:0]       i_data,
    input  logic [NUM_PINS-1:0]     i_ui_in,
    output logic [BYTE_W-1:0]       o_read_data,
    output logic [NUM_PINS-1:0]     o_uo_out
);

    logic [BYTE_W-1:0]    count;
    logic [PIN_IDX_W-1:0] pin_sel;
    logic [NUM_PINS-1:0]  ui_q;
    logic                 rise;

    assign rise = i_ui_in[pin_sel] & ~ui_q[pin_sel];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count   <= '0;
            pin_sel <= '0;
            ui_q    <= '0;
        end else begin
            ui_q <= i_ui_in;
            // A load takes priority over a counted edge
            if (i_wr && i_offset == 4'h0) begin
                count <= i_data;
            end else if (rise) begin
                count <= count + 1'b1;
            end
            if (i_wr && i_offset == 4'h1) begin
                pin_sel <= i_data[PIN_IDX_W-1:0];
            end
        end
    end

    always_comb begin
        case (i_offset)
            4'h0:    o_read_data = count;
            4'h1:    o_read_data = BYTE_W'(pin_sel);
            default: o_read_data = '0;
        endcase
    end

    assign o_uo_out = count;

endmodule

/* rtl/gpio_regs.sv */
// GPIO block
// Output byte register, input pin readback and one output function
// select per pin
`timescale 1ns/1ps

module gpio_regs
    import periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_wr,
    input  logic [FULL_OFS_W-1:0] i_offset,
    input  logic [BYTE_W-1:0]     i_data,
    input  logic [NUM_PINS-1:0]   i_ui_in,
    output logic [NUM_PINS-1:0]   o_gpio_out,
    output func_sel_t             o_func_sel [NUM_PINS],
    output logic [DATA_W-1:0]     o_read_data
);

    logic                 hit_out;
    logic                 hit_in;
    logic                 hit_func;
    logic [PIN_IDX_W-1:0] func_idx;

    // Function selects live at 0x20..0x3C, one word per pin
    assign hit_out  = (i_offset == 6'h00);
    assign hit_in   = (i_offset == 6'h04);
    assign hit_func = i_offset[5] && (i_offset[1:0] == 2'b00);
    assign func_idx = i_offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
        end else if (i_wr && hit_out) begin
            o_gpio_out <= i_data[NUM_PINS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PINS; i++) begin
                o_func_sel[i] <= FUNC_GPIO_DEFAULT;
            end
        end else if (i_wr && hit_func) begin
            o_func_sel[func_idx] <= i_data[FUNC_SEL_W-1:0];
        end
    end

    always_comb begin
        o_read_data = '0;
        if (hit_out) begin
            o_read_data = DATA_W'(o_gpio_out);
        end else if (hit_in) begin
            o_read_data = DATA_W'(i_ui_in);
        end else if (hit_func) begin
            o_read_data = DATA_W'(o_func_sel[func_idx]);
        end
    end

endmodule

/* rtl/periph_decode.sv */
// Peripheral address decoder
// Splits the address into full and simple slot selects, gives each
// peripheral its write strobe and local offset, and muxes read data back
`timescale 1ns/1ps

module periph_decode
    import periph_pkg::*;
(
    input  logic [ADDR_W-1:0]     i_addr,
    input  access_t               i_write_n,
    input  logic [DATA_W-1:0]     i_data_scratch,
    input  logic [DATA_W-1:0]     i_data_gpio,
    input  logic [BYTE_W-1:0]     i_data_counter,
    output logic                  o_wr_gpio,
    output logic                  o_wr_scratch,
    output logic                  o_wr_counter,
    output logic [FULL_OFS_W-1:0] o_offset,
    output logic [DATA_W-1:0]     o_read_data
);

    logic [NUM_SLOTS-1:0] sel_full;
    logic [NUM_SLOTS-1:0] sel_simple;
    logic                 is_simple;
    logic                 write_req;

    assign is_simple = i_addr[ADDR_W-1];
    assign write_req = (i_write_n != ACC_NONE);

    // One-hot slot selects
    always_comb begin
        sel_full   = '0;
        sel_simple = '0;
        if (is_simple) begin
            sel_simple[i_addr[7:4]] = 1'b1;
        end else begin
            sel_full[i_addr[9:6]] = 1'b1;
        end
    end

    assign o_wr_gpio    = write_req & sel_full[SLOT_GPIO];
    assign o_wr_scratch = write_req & sel_full[SLOT_SCRATCH];
    assign o_wr_counter = write_req & sel_simple[SIMPLE_COUNTER];

    // Simple slots only see the low nibble of the address
    assign o_offset = is_simple ? FULL_OFS_W'(i_addr[SIMPLE_OFS_W-1:0])
                                : i_addr[FULL_OFS_W-1:0];

    // Unmapped slots fall through to zero
    always_comb begin
        o_read_data = '0;
        if (sel_full[SLOT_GPIO]) begin
            o_read_data = i_data_gpio;
        end
        if (sel_full[SLOT_SCRATCH]) begin
            o_read_data = i_data_scratch;
        end
        if (sel_simple[SIMPLE_COUNTER]) begin
            o_read_data = DATA_W'(i_data_counter);
        end
    end

endmodule

/* rtl/periph_pkg.sv */
// Peripheral bus definitions
// Address map, access codes and shared widths for the peripheral wrapper
package periph_pkg;

    localparam int ADDR_W   = 11;
    localparam int DATA_W   = 32;
    localparam int NUM_PINS = 8;

    // Pin index width, used by the function select map and the edge counter
    localparam int PIN_IDX_W = $clog2(NUM_PINS);

    // 16 full slots of 64 bytes and 16 simple slots of 16 bytes
    localparam int SLOT_W       = 4;
    localparam int NUM_SLOTS    = 1 << SLOT_W;
    localparam int FULL_OFS_W   = 6;
    localparam int SIMPLE_OFS_W = 4;
    localparam int BYTE_W       = 8;

    localparam int FUNC_SEL_W = 5;

    localparam logic [SLOT_W-1:0] SLOT_GPIO      = 4'd1;
    localparam logic [SLOT_W-1:0] SLOT_SCRATCH   = 4'd4;
    localparam logic [SLOT_W-1:0] SIMPLE_COUNTER = 4'd0;

    // Access size on the core's read and write request lines
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_t;

    // Top bit picks a simple slot, low bits give the slot index
    typedef logic [FUNC_SEL_W-1:0] func_sel_t;

    localparam func_sel_t FUNC_GPIO_DEFAULT = {1'b0, SLOT_GPIO};

endpackage

/* rtl/periph_top.sv */
// Peripheral bus wrapper
// Connects the address decoder, GPIO, scratch bank, edge counter, output
// pin mux and the registered read return path
`timescale 1ns/1ps

module periph_top
    import periph_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_PINS-1:0] i_ui_in,
    input  logic [ADDR_W-1:0]   i_addr,
    input  logic [DATA_W-1:0]   i_data,
    input  access_t             i_write_n,
    input  access_t             i_read_n,
    input  logic                i_read_complete,
    output logic [DATA_W-1:0]   o_data,
    output logic                o_data_ready,
    output logic [NUM_PINS-1:0] o_uo_out
);

    logic                  wr_gpio;
    logic                  wr_scratch;
    logic                  wr_counter;
    logic [FULL_OFS_W-1:0] offset;
    logic [DATA_W-1:0]     read_data;
    logic [DATA_W-1:0]     data_gpio;
    logic [DATA_W-1:0]     data_scratch;
    logic [BYTE_W-1:0]     data_counter;
    logic [NUM_PINS-1:0]   gpio_out;
    logic [NUM_PINS-1:0]   scratch_out;
    logic [NUM_PINS-1:0]   counter_out;
    func_sel_t             func_sel [NUM_PINS];

    periph_decode u_decode (
        .i_addr         (i_addr),
        .i_write_n      (i_write_n),
        .i_data_scratch (data_scratch),
        .i_data_gpio    (data_gpio),
        .i_data_counter (data_counter),
        .o_wr_gpio      (wr_gpio),
        .o_wr_scratch   (wr_scratch),
        .o_wr_counter   (wr_counter),
        .o_offset       (offset),
        .o_read_data    (read_data)
    );

    read_return u_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_read_data     (read_data),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    gpio_regs u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_wr        (wr_gpio),
        .i_offset    (offset),
        .i_data      (i_data[BYTE_W-1:0]),
        .i_ui_in     (i_ui_in),
        .o_gpio_out  (gpio_out),
        .o_func_sel  (func_sel),
        .o_read_data (data_gpio)
    );

    pin_mux u_pins (
        .i_func_sel    (func_sel),
        .i_gpio_out    (gpio_out),
        .i_scratch_out (scratch_out),
        .i_counter_out (counter_out),
        .o_uo_out      (o_uo_out)
    );

    scratch_regs u_scratch (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_wr        (wr_scratch),
        .i_write_n   (i_write_n),
        .i_offset    (offset),
        .i_data      (i_data),
        .o_read_data (data_scratch),
        .o_uo_out    (scratch_out)
    );

    edge_counter u_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_wr        (wr_counter),
        .i_offset    (offset[SIMPLE_OFS_W-1:0]),
        .i_data      (i_data[BYTE_W-1:0]),
        .i_ui_in     (i_ui_in),
        .o_read_data (data_counter),
        .o_uo_out    (counter_out)
    );

endmodule

/* rtl/pin_mux.sv */
// Output pin multiplexer
// Each output pin takes its own bit from the peripheral named by its
// function select; unknown selects drive zero
`timescale 1ns/1ps

module pin_mux
    import periph_pkg::*;
(
    input  func_sel_t           i_func_sel [NUM_PINS],
    input  logic [NUM_PINS-1:0] i_gpio_out,
    input  logic [NUM_PINS-1:0] i_scratch_out,
    input  logic [NUM_PINS-1:0] i_counter_out,
    output logic [NUM_PINS-1:0] o_uo_out
);

    always_comb begin
        for (int i = 0; i < NUM_PINS; i++) begin
            case (i_func_sel[i])
                {1'b0, SLOT_GPIO}:      o_uo_out[i] = i_gpio_out[i];
                {1'b0, SLOT_SCRATCH}:   o_uo_out[i] = i_scratch_out[i];
                {1'b1, SIMPLE_COUNTER}: o_uo_out[i] = i_counter_out[i];
                default:                o_uo_out[i] = 1'b0;
            endcase
        end
    end

endmodule

/* rtl/read_return.sv */
// Read return path
// Captures the selected read data into a register and holds it until the
// core signals read complete; data ready follows the request by one cycle
`timescale 1ns/1ps

module read_return
    import periph_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  access_t           i_read_n,
    input  access_t           i_write_n,
    input  logic              i_read_complete,
    input  logic [DATA_W-1:0] i_read_data,
    output logic [DATA_W-1:0] o_data,
    output logic              o_data_ready
);

    logic [DATA_W-1:0] data_r;
    logic              hold;
    logic              ready_r;
    logic              read_req;

    assign read_req = (i_read_n != ACC_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            // A new capture wins over a complete in the same cycle
            if (!hold && read_req) begin
                hold <= 1'b1;
            end
            ready_r <= read_req;
        end
    end

    // Result stays put until the core has taken it
    always_ff @(posedge clk) begin
        if (!hold && read_req) begin
            data_r <= i_read_data;
        end
    end

    assign o_data = data_r;

    // Writes always complete in the cycle they are issued
    assign o_data_ready = ready_r | (i_write_n != ACC_NONE);

endmodule

/* rtl/scratch_regs.sv */
// Scratch register bank
// Four 32-bit words on the full interface, written by byte, halfword or
// word; the low byte of word 0 is offered to the pins
`timescale 1ns/1ps

module scratch_regs
    import periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_wr,
    input  access_t               i_write_n,
    input  logic [FULL_OFS_W-1:0] i_offset,
    input  logic [DATA_W-1:0]     i_data,
    output logic [DATA_W-1:0]     o_read_data,
    output logic [NUM_PINS-1:0]   o_uo_out
);

    logic [DATA_W-1:0] regs [4];
    logic              hit;
    logic [1:0]        idx;

    // Words at 0, 4, 8 and 12 only
    assign hit = (i_offset[5:4] == 2'b00) && (i_offset[1:0] == 2'b00);
    assign idx = i_offset[3:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr && hit) begin
            case (i_write_n)
                ACC_BYTE: regs[idx][7:0]  <= i_data[7:0];
                ACC_HALF: regs[idx][15:0] <= i_data[15:0];
                ACC_WORD: regs[idx]       <= i_data;
                default:  ;
            endcase
        end
    end

    assign o_read_data = hit ? regs[idx] : '0;
    assign o_uo_out    = regs[0][NUM_PINS-1:0];

endmodule

/* sim/periph_top_assert.sv */
// Peripheral wrapper assertions
// Read handshake timing, held read data and same-cycle write ready
`timescale 1ns/1ps

module periph_top_assert
    import periph_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input access_t           i_write_n,
    input access_t           i_read_n,
    input logic              i_read_complete,
    input logic [DATA_W-1:0] o_data,
    input logic              o_data_ready
);

    // Data ready one cycle after a read request is seen
    a_ready_after_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_read_n != ACC_NONE) |=> o_data_ready
    ) else $error("o_data_ready did not follow the read request");

    // Held result must not move until the core completes the read
    a_data_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_data_ready && !i_read_complete) |=> $stable(o_data)
    ) else $error("o_data changed while waiting for read complete");

    a_write_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_write_n != ACC_NONE) |-> o_data_ready
    ) else $error("o_data_ready low during a write");

endmodule

bind periph_top periph_top_assert u_assert (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_write_n       (i_write_n),
    .i_read_n        (i_read_n),
    .i_read_complete (i_read_complete),
    .o_data          (o_data),
    .o_data_ready    (o_data_ready)
);

/* sim/periph_vectors.txt */
# op addr size data expected, hex address, size 0 byte 1 half 2 word, hex data and expected
# W writes data, R reads and delays complete by data cycles, P drives i_ui_in with data
R 040 2 00000000 00000000
W 040 0 000000a5 00000000
R 040 2 00000000 000000a5
P 000 0 0000003c 00000000
R 044 2 00000000 0000003c
W 100 2 12345678 00000000
W 104 2 cafef00d 00000000
W 100 1 0000beef 00000000
R 100 2 00000000 1234beef
W 104 0 00000042 00000000
R 104 2 00000006 cafef042
W 401 0 00000002 00000000
R 401 0 00000000 00000002
P 000 0 00000000 00000000
P 000 0 00000004 00000000
P 000 0 00000000 00000000
P 000 0 000000fc 00000000
P 000 0 000000f8 00000000
P 000 0 00000004 00000000
R 400 0 00000000 00000003
W 400 0 000000f0 00000000
W 064 2 00000004 00000000
W 078 2 00000010 00000000
W 07c 2 0000001f 00000000
R 078 2 00000000 00000010
R 080 2 00000004 00000000
R 430 0 00000003 00000000
R 200 1 00000000 00000000

/* sim/tb_periph_top.sv */
// Peripheral wrapper testbench
// Replays the vectors file against the DUT, checks read data, write ready
// and the output pins against a model of the pin routing
`timescale 1ns/1ps

module tb_periph_top
    import periph_pkg::*;
();

    localparam int    CLK_PERIOD        = 40;
    localparam int    DRIVE_DELAY       = 2;
    localparam int    RESET_CYCLES      = 16;
    localparam int    CYCLES_PER_VECTOR = 20;
    localparam int    READY_WAIT        = 8;
    localparam string VEC_FILE          = "sim/periph_vectors.txt";

    logic                clk;
    logic                rst_n;
    logic [NUM_PINS-1:0] i_ui_in;
    logic [ADDR_W-1:0]   i_addr;
    logic [DATA_W-1:0]   i_data;
    access_t             i_write_n;
    access_t             i_read_n;
    logic                i_read_complete;
    logic [DATA_W-1:0]   o_data;
    logic                o_data_ready;
    logic [NUM_PINS-1:0] o_uo_out;

    logic [7:0]        vec_op   [$];
    logic [ADDR_W-1:0] vec_addr [$];
    logic [1:0]        vec_size [$];
    logic [DATA_W-1:0] vec_data [$];
    logic [DATA_W-1:0] vec_exp  [$];
    logic              load_ok;

    // Model of everything that can reach the output pins
    logic [7:0]          m_gpio;
    logic [7:0]          m_scratch0;
    logic [7:0]          m_count;
    logic [2:0]          m_pin_sel;
    logic [NUM_PINS-1:0] m_ui;
    func_sel_t           m_func [NUM_PINS];

    int data_errors;
    int pin_errors;
    int protocol_errors;
    int cycle_count;
    int limit_cycles;

    periph_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (i_ui_in),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .o_uo_out        (o_uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_vectors();
        int                fd;
        int                got;
        logic [7:0]        tok;
        logic [8*128-1:0]  rest;
        logic [ADDR_W-1:0] a;
        logic [1:0]        s;
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] e;
        load_ok = 1'b1;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            load_ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    got = $fgets(rest, fd);
                end else begin
                    got = $fscanf(fd, "%h %d %h %h", a, s, d, e);
                    if (got != 4) begin
                        load_ok = 1'b0;
                    end
                    vec_op.push_back(tok);
                    vec_addr.push_back(a);
                    vec_size.push_back(s);
                    vec_data.push_back(d);
                    vec_exp.push_back(e);
                end
            end
            $fclose(fd);
            if (vec_op.size() == 0) begin
                load_ok = 1'b0;
            end
        end
    endtask

    // Pins route from GPIO in slot 1, scratch word 0 in slot 4 and the counter in simple slot 0
    function automatic logic [NUM_PINS-1:0] expected_pins();
        logic [NUM_PINS-1:0] pins;
        pins = '0;
        for (int i = 0; i < NUM_PINS; i++) begin
            case (m_func[i])
                5'h01:   pins[i] = m_gpio[i];
                5'h04:   pins[i] = m_scratch0[i];
                5'h10:   pins[i] = m_count[i];
                default: pins[i] = 1'b0;
            endcase
        end
        return pins;
    endfunction

    function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                        input logic [DATA_W-1:0] data);
        logic [5:0] ofs;
        ofs = addr[5:0];
        if (!addr[10]) begin
            if (addr[9:6] == 4'd1) begin
                if (ofs == 6'h00) begin
                    m_gpio = data[7:0];
                end else if (ofs[5] && ofs[1:0] == 2'b00) begin
                    m_func[ofs[4:2]] = data[4:0];
                end
            end else if (addr[9:6] == 4'd4 && ofs == 6'h00) begin
                // Any write size reaches the low byte
                m_scratch0 = data[7:0];
            end
        end else if (addr[7:4] == 4'd0) begin
            if (addr[3:0] == 4'h0) begin
                m_count = data[7:0];
            end else if (addr[3:0] == 4'h1) begin
                m_pin_sel = data[2:0];
            end
        end
    endfunction

    function automatic void model_pins(input logic [NUM_PINS-1:0] value);
        if (value[m_pin_sel] && !m_ui[m_pin_sel]) begin
            m_count = m_count + 8'd1;
        end
        m_ui = value;
    endfunction

    function automatic void check_pins(input int idx);
        logic [NUM_PINS-1:0] want;
        want = expected_pins();
        if (o_uo_out !== want) begin
            pin_errors++;
            $display("CHECK FAILED at %0t: vector %0d o_uo_out %02h, expected %02h",
                     $time, idx, o_uo_out, want);
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic do_write(input int idx);
        i_addr    = vec_addr[idx];
        i_data    = vec_data[idx];
        i_write_n = access_t'(vec_size[idx]);
        #1;
        if (o_data_ready !== 1'b1) begin
            protocol_errors++;
            $display("CHECK FAILED at %0t: vector %0d write not ready in its own cycle",
                     $time, idx);
        end
        next_cycle();
        i_write_n = ACC_NONE;
        model_write(vec_addr[idx], vec_data[idx]);
    endtask

    task automatic do_read(input int idx);
        int                waited;
        int                holdoff;
        logic [DATA_W-1:0] want;
        waited  = 0;
        holdoff = int'(vec_data[idx]);
        want    = vec_exp[idx];
        i_addr   = vec_addr[idx];
        i_read_n = access_t'(vec_size[idx]);
        next_cycle();
        while (o_data_ready !== 1'b1 && waited < READY_WAIT) begin
            next_cycle();
            waited++;
        end
        if (o_data_ready !== 1'b1) begin
            protocol_errors++;
            $display("Read of address %03h got no data ready within %0d cycles",
                     vec_addr[idx], READY_WAIT);
        end else if (o_data !== want) begin
            data_errors++;
            $display("CHECK FAILED at %0t: vector %0d read %03h got %08h, expected %08h",
                     $time, idx, vec_addr[idx], o_data, want);
        end
        // Request stays up on another address while complete is late
        if (holdoff > 0) begin
            i_addr = ~vec_addr[idx];
        end
        for (int c = 0; c < holdoff; c++) begin
            next_cycle();
            if (o_data !== want) begin
                data_errors++;
                $display("CHECK FAILED at %0t: vector %0d held data %08h, expected %08h",
                         $time, idx, o_data, want);
            end
        end
        i_read_n        = ACC_NONE;
        i_read_complete = 1'b1;
        next_cycle();
        i_read_complete = 1'b0;
    endtask

    task automatic do_pins(input int idx);
        i_ui_in = vec_data[idx][NUM_PINS-1:0];
        next_cycle();
        model_pins(vec_data[idx][NUM_PINS-1:0]);
    endtask

    // Watchdog with its limit set once the vectors are loaded
    initial begin
        cycle_count = 0;
        while (!(limit_cycles > 0 && cycle_count > limit_cycles)) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run still going after %0d cycles", limit_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n           = 1'b0;
        i_ui_in         = '0;
        i_addr          = '0;
        i_data          = '0;
        i_write_n       = ACC_NONE;
        i_read_n        = ACC_NONE;
        i_read_complete = 1'b0;
        data_errors     = 0;
        pin_errors      = 0;
        protocol_errors = 0;
        limit_cycles    = 0;
        m_gpio          = '0;
        m_scratch0      = '0;
        m_count         = '0;
        m_pin_sel       = '0;
        m_ui            = '0;
        for (int i = 0; i < NUM_PINS; i++) begin
            m_func[i] = 5'h01;
        end
        load_vectors();
        if (!load_ok) begin
            $display("Could not read stimulus from %s", VEC_FILE);
            $display("CHECKS FAILED");
        end else begin
            limit_cycles = vec_op.size() * CYCLES_PER_VECTOR + RESET_CYCLES;
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rst_n = 1'b1;
            check_pins(-1);
            for (int i = 0; i < vec_op.size(); i++) begin
                case (vec_op[i])
                    "W": do_write(i);
                    "R": do_read(i);
                    "P": do_pins(i);
                    default: begin
                        protocol_errors++;
                        $display("Vector %0d has an unknown operation", i);
                    end
                endcase
                check_pins(i);
            end
            $display("Errors: data %0d, pins %0d, protocol %0d",
                     data_errors, pin_errors, protocol_errors);
            if (data_errors + pin_errors + protocol_errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
        end
        $finish;
    end

endmodule
